//--- hw/decode_defs.svh
// **************************************************
// widths and register map of the decode slave
// bus is word addressed, four 32-bit registers
// instruction and bus data widths must stay equal
// **************************************************
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define ILEN 32            // instruction word
`define XLEN 64            // immediate, RV64
`define WB_DW 32           // wishbone data
`define WB_AW 2            // word address bits

`define ADDR_INSTR 2'd0    // rw, instruction register
`define ADDR_CTRL 2'd1     // ro, masked control word
`define ADDR_IMM_LO 2'd2   // ro, imm[31:0]
`define ADDR_IMM_HI 2'd3   // ro, imm[63:32]

`define NOP_INSTR 32'h0000_0013  // addi x0,x0,0

`endif

//--- hw/rvIsaPkg.sv
// **************************************************
// RV64IM instruction encoding types
// only the opcodes listed here are decoded
// **************************************************
`default_nettype none

package rvIsaPkg;

  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,  // OP-IMM
    opOp     = 7'b0110011,  // OP
    opImm32  = 7'b0011011,  // OP-IMM-32
    opOp32   = 7'b0111011,  // OP-32
    opSystem = 7'b1110011
  } opcode_e;

  // immediate formats, same order as the legacy ExtOp
  typedef enum logic [2:0] {
    fmtI = 3'd0,
    fmtU = 3'd1,
    fmtS = 3'd2,
    fmtB = 3'd3,
    fmtJ = 3'd4,
    fmtR = 3'd5   // no immediate
  } immFmt_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } rFields_t;

  typedef struct packed {
    logic [6:0] immHi;  // inst[31:25]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;  // inst[11:7]
    opcode_e    opcode;
  } sFields_t;

  // one instruction word, two field views
  typedef union packed {
    rFields_t rView;  // decoders
    sFields_t sView;  // immediate assembly
  } rvInstr_u;

endpackage

`default_nettype wire

//--- hw/decodeCtrlPkg.sv
// **************************************************
// decoder output and bus types
// aluOp_e numbering follows the existing ALU
// control word is 30 bits, zero-extended on reads
// **************************************************
`default_nettype none

`include "decode_defs.svh"

package decodeCtrlPkg;
  import rvIsaPkg::*;

  // bit4 word form, bit3 alternate op, low bits funct3 for the base set
  typedef enum logic [4:0] {
    aluAdd = 5'd0, aluSll = 5'd1, aluSlt = 5'd2, aluSltu = 5'd3,
    aluXor = 5'd4, aluSrl = 5'd5, aluOr = 5'd6, aluAnd = 5'd7,
    aluSub = 5'd8, aluMul = 5'd9, aluDiv = 5'd10, aluDivu = 5'd11,
    aluRem = 5'd12, aluSra = 5'd13, aluRemu = 5'd14, aluPassB = 5'd15,
    aluAddw = 5'd16, aluSllw = 5'd17, aluSrlw = 5'd21, aluSubw = 5'd24,
    aluMulw = 5'd25, aluDivw = 5'd26, aluDivuw = 5'd27, aluRemw = 5'd28,
    aluSraw = 5'd29, aluRemuw = 5'd30
  } aluOp_e;

  typedef enum logic [2:0] {
    brNone = 3'd0, brJal = 3'd1, brJalr = 3'd2,
    brEq = 3'd4, brNe = 3'd5, brLt = 3'd6, brGe = 3'd7
  } branch_e;

  typedef enum logic [2:0] {
    memWord = 3'd0, memByte = 3'd1, memHalf = 3'd2, memDouble = 3'd3,
    memWordU = 3'd4, memByteU = 3'd5, memHalfU = 3'd6
  } memOp_e;

  typedef enum logic [1:0] {csrRw = 2'd0, csrSet = 2'd1, csrClear = 2'd2} csrOp_e;

  typedef enum logic [1:0] {
    mulLow = 2'd0, mulHighSS = 2'd1, mulHighSU = 2'd2, mulHighUU = 2'd3
  } mulOp_e;

  typedef struct packed {
    logic       aluSrcA;  // 0 pc, 1 rs1
    logic [1:0] aluSrcB;  // 0 rs2, 1 imm, 2 const 4
    aluOp_e     aluOp;
    mulOp_e     mulOp;
    branch_e    branch;
    immFmt_e    immFmt;
  } aluCtrl_t;

  typedef struct packed {
    memOp_e memOp;
    logic   memToReg;
    logic   memWen;
    logic   regWen;
    logic   csrWen;
    logic   csrToReg;
    csrOp_e csrOp;
    logic   ecall;
    logic   ebreak;
    logic   mret;
  } memSysCtrl_t;

  typedef struct packed {
    aluCtrl_t    alu;
    memSysCtrl_t memSys;
    logic        illegal;  // lsb of the read word
  } ctrlWord_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [`WB_AW-1:0] adr;  // word address
    logic [`WB_DW-1:0] dat;
  } wbReq_t;

  typedef struct packed {
    logic             ack;
    logic [`WB_DW-1:0] dat;
  } wbRsp_t;

endpackage

`default_nettype wire

//--- hw/aluOpDecoder.sv
// **************************************************
// ALU side decode, purely combinational
// owns opcode legality and the ALU, branch and jump
// funct checks; unknown funct7 on OP falls back to
// the base op as the existing ALU expects
// **************************************************
`default_nettype none

module aluOpDecoder import rvIsaPkg::*, decodeCtrlPkg::*; (
  input  rvInstr_u instr,
  output aluCtrl_t aluCtrl,
  output logic     aluLegal
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       altBit;    // inst[30]
  logic       isMulDiv;  // M-extension funct7
  logic       isSubFn7;  // sub/subw funct7

  // base and word ops are {word, alt, funct3}
  function automatic aluOp_e intOp(input logic word, input logic alt, input logic [2:0] f3);
    return aluOp_e'({word, alt, f3});
  endfunction

  assign funct3   = instr.rView.funct3;
  assign funct7   = instr.rView.funct7;
  assign altBit   = funct7[5];
  assign isMulDiv = (funct7 == 7'b0000001);
  assign isSubFn7 = (funct7 == 7'b0100000);

  always_comb begin
    aluCtrl.aluSrcA = 1'b1;
    aluCtrl.aluSrcB = 2'd0;
    aluCtrl.aluOp   = aluAdd;
    aluCtrl.mulOp   = mulLow;
    aluCtrl.branch  = brNone;
    aluCtrl.immFmt  = fmtR;
    aluLegal        = 1'b1;
    case (instr.rView.opcode)
      opLui: begin
        aluCtrl.aluSrcB = 2'd1;
        aluCtrl.aluOp   = aluPassB;  // result is the U immediate
        aluCtrl.immFmt  = fmtU;
      end
      opAuipc: begin
        aluCtrl.aluSrcA = 1'b0;  // pc + imm
        aluCtrl.aluSrcB = 2'd1;
        aluCtrl.immFmt  = fmtU;
      end
      opJal, opJalr: begin
        aluCtrl.aluSrcA = 1'b0;  // link = pc + 4
        aluCtrl.aluSrcB = 2'd2;
        aluCtrl.branch  = (instr.rView.opcode == opJal) ? brJal : brJalr;
        aluCtrl.immFmt  = (instr.rView.opcode == opJal) ? fmtJ : fmtI;
      end
      opImm: begin
        aluCtrl.aluSrcB = 2'd1;
        aluCtrl.immFmt  = fmtI;
        aluCtrl.aluOp   = intOp(1'b0, altBit && funct3 == 3'b101, funct3);  // srai only
      end
      opImm32: begin
        aluCtrl.aluSrcB = 2'd1;
        aluCtrl.immFmt  = fmtI;
        if (funct3 == 3'b000) aluCtrl.aluOp = aluAddw;
        else if (funct3 == 3'b001) aluCtrl.aluOp = aluSllw;
        else aluCtrl.aluOp = intOp(1'b1, altBit, 3'b101);  // srliw/sraiw
      end
      opOp: begin
        if (isMulDiv) begin
          if (!funct3[2]) begin
            aluCtrl.aluOp = aluMul;
            aluCtrl.mulOp = mulOp_e'(funct3[1:0]);  // mul, mulh, mulhsu, mulhu
          end else begin
            case (funct3[1:0])
              2'b00:   aluCtrl.aluOp = aluDiv;
              2'b01:   aluCtrl.aluOp = aluDivu;
              2'b10:   aluCtrl.aluOp = aluRem;
              default: aluCtrl.aluOp = aluRemu;
            endcase
          end
        end else begin
          aluCtrl.aluOp = intOp(1'b0,
                                (funct3 == 3'b000 && isSubFn7) || (funct3 == 3'b101 && altBit),
                                funct3);
        end
      end
      opOp32: begin
        if (isMulDiv) begin
          case (funct3)
            3'b000:  aluCtrl.aluOp = aluMulw;
            3'b100:  aluCtrl.aluOp = aluDivw;
            3'b101:  aluCtrl.aluOp = aluDivuw;
            3'b110:  aluCtrl.aluOp = aluRemw;
            3'b111:  aluCtrl.aluOp = aluRemuw;
            default: aluLegal = 1'b0;  // no mulhw in RV64M
          endcase
        end else if (funct3 == 3'b000) begin
          aluCtrl.aluOp = isSubFn7 ? aluSubw : aluAddw;
        end else if (funct3 == 3'b001) begin
          aluCtrl.aluOp = aluSllw;
        end else begin
          aluCtrl.aluOp = intOp(1'b1, altBit, 3'b101);  // srlw/sraw
        end
      end
      opBranch: begin
        aluCtrl.immFmt = fmtB;
        aluCtrl.aluOp  = funct3[1] ? aluSltu : aluSlt;  // bltu/bgeu compare unsigned
        case (funct3)
          3'b000:         aluCtrl.branch = brEq;
          3'b001:         aluCtrl.branch = brNe;
          3'b100, 3'b110: aluCtrl.branch = brLt;
          3'b101, 3'b111: aluCtrl.branch = brGe;
          default:        aluLegal = 1'b0;
        endcase
      end
      opLoad, opSystem: begin
        aluCtrl.aluSrcB = 2'd1;  // rs1 + imm
        aluCtrl.immFmt  = fmtI;
      end
      opStore: begin
        aluCtrl.aluSrcB = 2'd1;
        aluCtrl.immFmt  = fmtS;
      end
      default: aluLegal = 1'b0;  // unknown opcode
    endcase
  end

endmodule

`default_nettype wire

//--- hw/memSysDecoder.sv
// **************************************************
// memory, writeback, CSR and trap decode
// combinational; opcode legality is checked by
// the ALU decoder, so regWen defaults high here
// **************************************************
`default_nettype none

module memSysDecoder import rvIsaPkg::*, decodeCtrlPkg::*; (
  input  rvInstr_u    instr,
  output memSysCtrl_t memSysCtrl,
  output logic        memSysLegal
);

  logic [2:0]  funct3;
  logic [11:0] funct12;  // inst[31:20]

  // load/store width from funct3, bit2 marks zero-extend
  function automatic memOp_e widthOp(input logic [2:0] f3);
    case (f3)
      3'b000:  return memByte;
      3'b001:  return memHalf;
      3'b011:  return memDouble;
      3'b100:  return memByteU;
      3'b101:  return memHalfU;
      3'b110:  return memWordU;
      default: return memWord;  // lw, and the unused 111
    endcase
  endfunction

  assign funct3  = instr.rView.funct3;
  assign funct12 = {instr.rView.funct7, instr.rView.rs2};

  always_comb begin
    memSysCtrl.memOp    = memWord;
    memSysCtrl.memToReg = 1'b0;
    memSysCtrl.memWen   = 1'b0;
    memSysCtrl.regWen   = 1'b1;
    memSysCtrl.csrWen   = 1'b0;
    memSysCtrl.csrToReg = 1'b0;
    memSysCtrl.csrOp    = csrRw;
    memSysCtrl.ecall    = 1'b0;
    memSysCtrl.ebreak   = 1'b0;
    memSysCtrl.mret     = 1'b0;
    memSysLegal         = 1'b1;
    case (instr.rView.opcode)
      opLoad: begin
        memSysCtrl.memOp    = widthOp(funct3);
        memSysCtrl.memToReg = 1'b1;
        if (funct3 == 3'b111) memSysLegal = 1'b0;  // no ldu
      end
      opStore: begin
        memSysCtrl.memOp  = widthOp(funct3);
        memSysCtrl.memWen = 1'b1;
        memSysCtrl.regWen = 1'b0;
        if (funct3[2]) memSysLegal = 1'b0;  // sb..sd only
      end
      opBranch: memSysCtrl.regWen = 1'b0;
      opSystem: begin
        case (funct3)
          3'b000: begin
            memSysCtrl.regWen = 1'b0;  // traps write nothing
            case (funct12)
              12'h000: memSysCtrl.ecall  = 1'b1;
              12'h001: memSysCtrl.ebreak = 1'b1;
              12'h302: memSysCtrl.mret   = 1'b1;
              default: memSysLegal       = 1'b0;
            endcase
          end
          3'b001, 3'b010, 3'b011: begin
            memSysCtrl.csrWen   = 1'b1;
            memSysCtrl.csrToReg = 1'b1;  // rd gets old csr
            memSysCtrl.csrOp    = csrOp_e'(funct3[1:0] - 2'd1);  // rw, set, clear
          end
          default: memSysLegal = 1'b0;  // no csr*i forms
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/immGen.sv
// **************************************************
// 64-bit immediate builder
// sign taken from inst[31]; format R yields zero
// **************************************************
`default_nettype none

`include "decode_defs.svh"

module immGen import rvIsaPkg::*; (
  input  rvInstr_u          instr,
  input  immFmt_e           immFmt,
  output logic [`XLEN-1:0] imm
);

  sFields_t f;
  logic     sign;

  assign f    = instr.sView;
  assign sign = f.immHi[6];  // inst[31]

  always_comb begin
    case (immFmt)
      fmtI: imm = {{(`XLEN-12){sign}}, f.immHi, f.rs2};  // inst[31:20]
      fmtS: imm = {{(`XLEN-12){sign}}, f.immHi, f.immLo};
      fmtB: imm = {{(`XLEN-12){sign}}, f.immLo[0], f.immHi[5:0], f.immLo[4:1], 1'b0};
      fmtU: imm = {{(`XLEN-32){sign}}, f.immHi, f.rs2, f.rs1, f.funct3, 12'h000};
      fmtJ: begin
        // imm[19:12] sits in rs1/funct3, imm[11] in rs2[0]
        imm = {{(`XLEN-20){sign}}, f.rs1, f.funct3, f.rs2[0], f.immHi[5:0], f.rs2[4:1], 1'b0};
      end
      default: imm = '0;  // R, nothing to extend
    endcase
  end

endmodule

`default_nettype wire

//--- hw/decodeCtrl.sv
// **************************************************
// wishbone classic slave, single transfers only
// ack one cycle after cyc&stb, never stalls
// writes outside ADDR_INSTR are acked and dropped
// illegal decodes read back with write enables low
// **************************************************
`default_nettype none

`include "decode_defs.svh"

module decodeCtrl import rvIsaPkg::*, decodeCtrlPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  wbReq_t            wbReq,
  output wbRsp_t            wbRsp,
  output rvInstr_u          instr,
  input  aluCtrl_t          aluCtrl,
  input  logic              aluLegal,
  input  memSysCtrl_t       memSysCtrl,
  input  logic              memSysLegal,
  input  logic [`XLEN-1:0] imm
);

  rvInstr_u          instrReg;
  logic              ackReg;
  logic [`WB_DW-1:0] rdData;   // registered read data
  logic [`WB_DW-1:0] readMux;
  logic              reqValid; // new transfer this cycle
  logic              illegal;
  ctrlWord_t         ctrlWord;

  assign reqValid = wbReq.cyc && wbReq.stb && !ackReg;  // skip the held cycle under ack
  assign illegal  = !(aluLegal && memSysLegal);

  always_comb begin
    ctrlWord.alu     = aluCtrl;
    ctrlWord.memSys  = memSysCtrl;
    ctrlWord.illegal = illegal;
    if (illegal) begin
      ctrlWord.memSys.regWen = 1'b0;  // no side effects
      ctrlWord.memSys.memWen = 1'b0;
      ctrlWord.memSys.csrWen = 1'b0;
    end
  end

  always_comb begin
    case (wbReq.adr)
      `ADDR_INSTR:  readMux = instrReg;
      `ADDR_CTRL:   readMux = {{(`WB_DW - $bits(ctrlWord_t)){1'b0}}, ctrlWord};
      `ADDR_IMM_LO: readMux = imm[`WB_DW-1:0];
      default:      readMux = imm[`XLEN-1:`WB_DW];  // ADDR_IMM_HI
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ackReg   <= 1'b0;
      rdData   <= '0;
      instrReg <= `NOP_INSTR;
    end else begin
      ackReg <= reqValid;
      if (reqValid && wbReq.we && wbReq.adr == `ADDR_INSTR)
        instrReg <= wbReq.dat[`ILEN-1:0];  // decoders see it next cycle
      if (reqValid && !wbReq.we)
        rdData <= readMux;
    end
  end

  assign instr     = instrReg;
  assign wbRsp.ack = ackReg;
  assign wbRsp.dat = rdData;

endmodule

`default_nettype wire

//--- hw/instrDecodeTop.sv
// **************************************************
// decode unit top, bus slave plus three decoders
// no execution, register file or CSR storage
// **************************************************
`default_nettype none

`include "decode_defs.svh"

module instrDecodeTop import rvIsaPkg::*, decodeCtrlPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  wbReq_t wbReq,
  output wbRsp_t wbRsp
);

  rvInstr_u          instr;
  aluCtrl_t          aluCtrl;
  logic              aluLegal;
  memSysCtrl_t       memSysCtrl;
  logic              memSysLegal;
  logic [`XLEN-1:0] imm;

  decodeCtrl uCtrl (
    .clk        (clk),
    .reset      (reset),
    .wbReq      (wbReq),
    .wbRsp      (wbRsp),
    .instr      (instr),
    .aluCtrl    (aluCtrl),
    .aluLegal   (aluLegal),
    .memSysCtrl (memSysCtrl),
    .memSysLegal(memSysLegal),
    .imm        (imm)
  );

  aluOpDecoder uAluDec (.instr(instr), .aluCtrl(aluCtrl), .aluLegal(aluLegal));

  memSysDecoder uMemSysDec (.instr(instr), .memSysCtrl(memSysCtrl), .memSysLegal(memSysLegal));

  immGen uImmGen (.instr(instr), .immFmt(aluCtrl.immFmt), .imm(imm));  // format from ALU side

endmodule

`default_nettype wire

//--- tests/decodeWb_assert.sv
// **************************************************
// bus protocol and illegal masking checks
// bound into decodeCtrl, single transfers assumed
// **************************************************
`default_nettype none

module decodeWbAssert import decodeCtrlPkg::*; (
  input logic      clk,
  input logic      reset,
  input wbReq_t    wbReq,
  input wbRsp_t    wbRsp,
  input ctrlWord_t ctrlWord
);
  timeunit 1ns;
  timeprecision 1ps;

  ackAfterReq: assert property (@(posedge clk) disable iff (reset)
    wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb && !wbRsp.ack))
    else $error("ack raised without a sampled cyc and stb");

  ackOneCycle: assert property (@(posedge clk) disable iff (reset)
    wbRsp.ack |=> !wbRsp.ack)
    else $error("ack lasted two cycles");

  // enables must be masked whenever the decode is illegal
  illegalMasked: assert property (@(posedge clk) disable iff (reset)
    ctrlWord.illegal |-> !(ctrlWord.memSys.regWen || ctrlWord.memSys.memWen ||
                           ctrlWord.memSys.csrWen))
    else $error("illegal decode with a write enable set");

endmodule

`default_nettype wire

//--- tests/decodeTb.sv
// **************************************************
// directed testbench for the decode slave
// one bus transfer at a time with inputs driven 1 ns
// after the rising edge; expected words follow ISA rules
// **************************************************
`default_nettype none

`include "decode_defs.svh"

module decodeTb import rvIsaPkg::*, decodeCtrlPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int maxCycles = 2000;  // tests need about 400

  logic        clk;
  logic        reset;
  wbReq_t      wbReq;
  wbRsp_t      wbRsp;
  int          errors = 0;
  int          cycles = 0;
  int          ackWait;             // edges from request to ack
  logic [15:0] lfsr = 16'd11;

  // expected values per funct3
  aluOp_e  baseOps [8] = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};
  aluOp_e  mdOps [8] = '{aluMul, aluMul, aluMul, aluMul, aluDiv, aluDivu, aluRem, aluRemu};
  mulOp_e  mdMul [8] = '{mulLow, mulHighSS, mulHighSU, mulHighUU, mulLow, mulLow, mulLow, mulLow};
  memOp_e  widthOps [7] = '{memByte, memHalf, memWord, memDouble, memByteU, memHalfU, memWordU};
  logic [2:0] brF3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  branch_e brCodes [6] = '{brEq, brNe, brLt, brGe, brLt, brGe};
  csrOp_e  csrOps [3] = '{csrRw, csrSet, csrClear};

  instrDecodeTop DUT (.clk(clk), .reset(reset), .wbReq(wbReq), .wbRsp(wbRsp));

  bind decodeCtrl decodeWbAssert uWbAssert (
    .clk     (clk),
    .reset   (reset),
    .wbReq   (wbReq),
    .wbRsp   (wbRsp),
    .ctrlWord(ctrlWord)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("timeout: run did not finish within %0d cycles", maxCycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic lfsrStep();
    logic outBit;
    outBit = lfsr[0];
    lfsr = lfsr >> 1;
    if (outBit)
      lfsr = lfsr ^ 16'hB400;  // galois taps 16,14,13,11
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrStep()};
    end
    return v;
  endfunction

  // R-layout word with random register fields
  function automatic logic [31:0] randInstr(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [6:0] op);
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [4:0] rd;
    rs2 = 5'(randBits(5));
    rs1 = 5'(randBits(5));
    rd  = 5'(randBits(5));
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // plain rs1-rs2 op that writes rd
  function automatic ctrlWord_t baseWord();
    ctrlWord_t w;
    w = '0;
    w.alu.aluSrcA   = 1'b1;
    w.alu.immFmt    = fmtR;
    w.memSys.regWen = 1'b1;
    return w;
  endfunction

  task automatic expectEq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic busXfer(input logic we, input logic [`WB_AW-1:0] adr,
                         input logic [`WB_DW-1:0] wdat, output logic [`WB_DW-1:0] rdat);
    int waited;
    waited = 0;
    wbReq.cyc = 1'b1;
    wbReq.stb = 1'b1;
    wbReq.we  = we;
    wbReq.adr = adr;
    wbReq.dat = we ? wdat : '0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wbRsp.ack && waited < 8);
    ackWait = waited;
    rdat = wbRsp.dat;  // valid while ack high
    if (!wbRsp.ack) begin
      errors++;
      $display("no ack within %0d cycles of the request", waited);
    end
    wbReq = '0;
    @(posedge clk);
    #1;
    if (wbRsp.ack) begin
      errors++;
      $display("ack stayed high for a second cycle");
    end
  endtask

  task automatic busWrite(input logic [`WB_AW-1:0] adr, input logic [`WB_DW-1:0] data);
    logic [`WB_DW-1:0] ignored;
    busXfer(1'b1, adr, data, ignored);
  endtask

  task automatic busRead(input logic [`WB_AW-1:0] adr, output logic [`WB_DW-1:0] data);
    busXfer(1'b0, adr, '0, data);
  endtask

  task automatic decodeCheck(input string name, input logic [31:0] word, input ctrlWord_t exp);
    logic [31:0] data;
    busWrite(`ADDR_INSTR, word);
    busRead(`ADDR_CTRL, data);
    expectEq(name, {34'b0, exp}, {32'b0, data});  // upper two bits read zero
  endtask

  task automatic illegalCheck(input string name, input logic [31:0] word);
    logic [31:0] data;
    ctrlWord_t   w;
    busWrite(`ADDR_INSTR, word);
    busRead(`ADDR_CTRL, data);
    w = ctrlWord_t'(data[29:0]);
    expectEq({name, " illegal"}, 64'd1, 64'(w.illegal));
    expectEq({name, " enables"}, 64'd0, 64'({w.memSys.regWen, w.memSys.memWen, w.memSys.csrWen}));
  endtask

  task automatic immCheck(input string name, input logic [31:0] word, input logic [63:0] exp);
    logic [31:0] lo;
    logic [31:0] hi;
    busWrite(`ADDR_INSTR, word);
    busRead(`ADDR_IMM_LO, lo);
    busRead(`ADDR_IMM_HI, hi);
    expectEq(name, exp, {hi, lo});
  endtask

  // register forms take rs2 and immediate forms the I immediate
  task automatic intCase(input string name, input opcode_e op, input logic [6:0] f7,
                         input logic [2:0] f3, input aluOp_e expOp, input mulOp_e expMul);
    ctrlWord_t exp;
    exp = baseWord();
    exp.alu.aluOp = expOp;
    exp.alu.mulOp = expMul;
    if (op == opImm || op == opImm32) begin
      exp.alu.aluSrcB = 2'd1;
      exp.alu.immFmt  = fmtI;
    end
    decodeCheck(name, randInstr(f7, f3, op), exp);
  endtask

  task automatic resetState();
    logic [31:0] data;
    ctrlWord_t   exp;
    exp = baseWord();
    exp.alu.aluSrcB = 2'd1;  // addi x0,x0,0
    exp.alu.immFmt  = fmtI;
    expectEq("reset ack", 64'd0, 64'(wbRsp.ack));
    expectEq("reset read data", 64'd0, 64'(wbRsp.dat));
    busRead(`ADDR_INSTR, data);
    expectEq("reset instr", 64'(`NOP_INSTR), {32'b0, data});
    busRead(`ADDR_CTRL, data);
    expectEq("reset ctrl", {34'b0, exp}, {32'b0, data});
    busRead(`ADDR_IMM_LO, data);
    expectEq("reset imm lo", 64'd0, {32'b0, data});
    busRead(`ADDR_IMM_HI, data);
    expectEq("reset imm hi", 64'd0, {32'b0, data});
  endtask

  task automatic aluAndJumps();
    ctrlWord_t exp;
    for (int f3 = 0; f3 < 8; f3++) begin
      intCase($sformatf("op f3=%0d", f3), opOp, 7'h00, 3'(f3), baseOps[f3], mulLow);
      intCase($sformatf("op-imm f3=%0d", f3), opImm, 7'h00, 3'(f3), baseOps[f3], mulLow);
    end
    intCase("sub", opOp, 7'h20, 3'd0, aluSub, mulLow);
    intCase("sra", opOp, 7'h20, 3'd5, aluSra, mulLow);
    intCase("srai", opImm, 7'h20, 3'd5, aluSra, mulLow);  // bit 30 picks sra
    intCase("addw", opOp32, 7'h00, 3'd0, aluAddw, mulLow);
    intCase("subw", opOp32, 7'h20, 3'd0, aluSubw, mulLow);
    intCase("sllw", opOp32, 7'h00, 3'd1, aluSllw, mulLow);
    intCase("srlw", opOp32, 7'h00, 3'd5, aluSrlw, mulLow);
    intCase("sraw", opOp32, 7'h20, 3'd5, aluSraw, mulLow);
    intCase("addiw", opImm32, 7'h00, 3'd0, aluAddw, mulLow);
    intCase("slliw", opImm32, 7'h00, 3'd1, aluSllw, mulLow);
    intCase("srliw", opImm32, 7'h00, 3'd5, aluSrlw, mulLow);
    intCase("sraiw", opImm32, 7'h20, 3'd5, aluSraw, mulLow);
    exp = baseWord();
    exp.alu.aluSrcB = 2'd1;
    exp.alu.aluOp   = aluPassB;
    exp.alu.immFmt  = fmtU;
    decodeCheck("lui", randInstr(7'(randBits(7)), 3'(randBits(3)), opLui), exp);
    exp.alu.aluSrcA = 1'b0;  // pc + imm
    exp.alu.aluOp   = aluAdd;
    decodeCheck("auipc", randInstr(7'(randBits(7)), 3'(randBits(3)), opAuipc), exp);
    exp.alu.aluSrcB = 2'd2;  // link pc + 4
    exp.alu.branch  = brJal;
    exp.alu.immFmt  = fmtJ;
    decodeCheck("jal", randInstr(7'(randBits(7)), 3'(randBits(3)), opJal), exp);
    exp.alu.branch = brJalr;
    exp.alu.immFmt = fmtI;
    decodeCheck("jalr", randInstr(7'(randBits(7)), 3'd0, opJalr), exp);
  endtask

  task automatic mulDiv();
    for (int f3 = 0; f3 < 8; f3++) begin
      intCase($sformatf("m-ext f3=%0d", f3), opOp, 7'h01, 3'(f3), mdOps[f3], mdMul[f3]);
    end
    intCase("mulw", opOp32, 7'h01, 3'd0, aluMulw, mulLow);
    intCase("divw", opOp32, 7'h01, 3'd4, aluDivw, mulLow);
    intCase("divuw", opOp32, 7'h01, 3'd5, aluDivuw, mulLow);
    intCase("remw", opOp32, 7'h01, 3'd6, aluRemw, mulLow);
    intCase("remuw", opOp32, 7'h01, 3'd7, aluRemuw, mulLow);
    illegalCheck("op-32 mul f3=1", randInstr(7'h01, 3'd1, opOp32));
  endtask

  task automatic loadsStoresImms();
    ctrlWord_t   exp;
    logic [11:0] imm12;
    logic [12:0] imm13;
    logic [19:0] imm20;
    logic [20:0] imm21;
    for (int f3 = 0; f3 < 7; f3++) begin
      exp = baseWord();
      exp.alu.aluSrcB     = 2'd1;
      exp.alu.immFmt      = fmtI;
      exp.memSys.memOp    = widthOps[f3];
      exp.memSys.memToReg = 1'b1;
      decodeCheck($sformatf("load f3=%0d", f3), randInstr(7'(randBits(7)), 3'(f3), opLoad), exp);
    end
    for (int f3 = 0; f3 < 4; f3++) begin
      exp = baseWord();
      exp.alu.aluSrcB   = 2'd1;
      exp.alu.immFmt    = fmtS;
      exp.memSys.memOp  = widthOps[f3];
      exp.memSys.memWen = 1'b1;
      exp.memSys.regWen = 1'b0;
      decodeCheck($sformatf("store f3=%0d", f3), randInstr(7'(randBits(7)), 3'(f3), opStore), exp);
    end
    for (int round = 0; round < 3; round++) begin
      imm12 = 12'(randBits(12));
      immCheck("imm I", {imm12, 5'(randBits(5)), 3'd0, 5'(randBits(5)), opImm},
               {{52{imm12[11]}}, imm12});
      imm12 = 12'(randBits(12));
      immCheck("imm S", {imm12[11:5], 10'(randBits(10)), 3'd2, imm12[4:0], opStore},
               {{52{imm12[11]}}, imm12});
      imm13 = {12'(randBits(12)), 1'b0};
      immCheck("imm B", {imm13[12], imm13[10:5], 10'(randBits(10)), 3'd0, imm13[4:1], imm13[11],
                         opBranch}, {{51{imm13[12]}}, imm13});
      imm20 = 20'(randBits(20));
      immCheck("imm U", {imm20, 5'(randBits(5)), opLui}, {{32{imm20[19]}}, imm20, 12'h000});
      imm21 = {20'(randBits(20)), 1'b0};
      immCheck("imm J", {imm21[20], imm21[10:1], imm21[11], imm21[19:12], 5'(randBits(5)), opJal},
               {{43{imm21[20]}}, imm21});
    end
  endtask

  task automatic branchSysIllegal();
    ctrlWord_t exp;
    for (int i = 0; i < 6; i++) begin
      exp = baseWord();
      exp.alu.immFmt    = fmtB;
      exp.alu.branch    = brCodes[i];
      exp.alu.aluOp     = (brF3s[i] == 3'd6 || brF3s[i] == 3'd7) ? aluSltu : aluSlt;
      exp.memSys.regWen = 1'b0;
      decodeCheck($sformatf("branch f3=%0d", brF3s[i]),
                  randInstr(7'(randBits(7)), brF3s[i], opBranch), exp);
    end
    exp = baseWord();
    exp.alu.aluSrcB   = 2'd1;
    exp.alu.immFmt    = fmtI;
    exp.memSys.regWen = 1'b0;  // traps write nothing
    exp.memSys.ecall  = 1'b1;
    decodeCheck("ecall", {12'h000, 13'd0, opSystem}, exp);
    exp.memSys.ecall  = 1'b0;
    exp.memSys.ebreak = 1'b1;
    decodeCheck("ebreak", {12'h001, 13'd0, opSystem}, exp);
    exp.memSys.ebreak = 1'b0;
    exp.memSys.mret   = 1'b1;
    decodeCheck("mret", {12'h302, 13'd0, opSystem}, exp);
    for (int f3 = 1; f3 < 4; f3++) begin
      exp = baseWord();
      exp.alu.aluSrcB     = 2'd1;
      exp.alu.immFmt      = fmtI;
      exp.memSys.csrWen   = 1'b1;
      exp.memSys.csrToReg = 1'b1;
      exp.memSys.csrOp    = csrOps[f3-1];
      decodeCheck($sformatf("csr f3=%0d", f3), randInstr(7'(randBits(7)), 3'(f3), opSystem), exp);
    end
    illegalCheck("unknown opcode", randInstr(7'h00, 3'd0, 7'b1111111));
    illegalCheck("branch f3=2", randInstr(7'h00, 3'd2, opBranch));
    illegalCheck("load f3=7", randInstr(7'h00, 3'd7, opLoad));
    illegalCheck("system funct12=5", {12'h005, 13'd0, opSystem});
  endtask

  // ack expected one edge after the request
  task automatic busProtocol();
    logic [31:0] data;
    logic [31:0] word;
    word = randInstr(7'h00, 3'd0, opImm);
    busWrite(`ADDR_INSTR, word);
    expectEq("write ack latency", 64'd1, 64'(ackWait));
    busWrite(`ADDR_CTRL, ~word);  // read-only register drops it
    busRead(`ADDR_INSTR, data);
    expectEq("read ack latency", 64'd1, 64'(ackWait));
    expectEq("instr after ctrl write", 64'(word), 64'(data));
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    wbReq = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    resetState();
    aluAndJumps();
    mulDiv();
    loadsStoresImms();
    branchSysIllegal();
    busProtocol();
    $display("all tests done, %0d errors", errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/rvIsaPkg.sv
hw/decodeCtrlPkg.sv
hw/aluOpDecoder.sv
hw/memSysDecoder.sv
hw/immGen.sv
hw/decodeCtrl.sv
hw/instrDecodeTop.sv
tests/decodeWb_assert.sv
tests/decodeTb.sv

//--- Makefile
TOP := decodeTb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f --top-module $(TOP) -o simv

run: build
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
